//--- compile.f
+incdir+include
verilog/pcie_tlp_pkg.sv
verilog/tlp_rx_realign.sv
verilog/tlp_tx_adapter.sv
verilog/pcie_tlp_bridge.sv
tb/pcie_tlp_bridge_asserts.sv
tb/tb_pcie_tlp_bridge.sv

//--- include/pcie_tlp_params.svh
/*
 * beat geometry and core rx user-word bit positions for the 128-bit bridge
 * the user-word layout assumes the 7-series core, which flags at most one sof per beat
 */
`ifndef PCIE_TLP_PARAMS_SVH
`define PCIE_TLP_PARAMS_SVH

// ----------------------------------------------------------------------
// beat geometry
// ----------------------------------------------------------------------
`define TLP_DATA_W          128
`define TLP_QW_W            64
`define TLP_DW_W            32
`define TLP_DW_PER_BEAT     4
`define TLP_KEEP_BYTES      16
`define TLP_KEEPDW_RST      4'b0000     // keep of an idle rx output beat

// ----------------------------------------------------------------------
// core receive user word
// ----------------------------------------------------------------------
`define RX_USER_W           22
`define BAR_HIT_W           7
`define RX_USER_SOF         14
`define RX_USER_SOF_QW      13          // tlp starts in upper quadword
`define RX_USER_EOF         21
`define RX_USER_EOF_DW_HI   20
`define RX_USER_EOF_DW_LO   19
`define RX_USER_BAR_LO      2
`define RX_USER_BAR_HI      8

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and scan the log for failure

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_pcie_tlp_bridge \
    --Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error" >> sim.log

cat sim.log 2>/dev/null

# a run is good only if it reached the pass line and never failed
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

//--- tb/pcie_tlp_bridge_asserts.sv
/*
 * tx handshake properties, bound into every tlp_tx_adapter
 * only the adapter's ports are observed
 */
`timescale 1ns/1ps
`include "pcie_tlp_params.svh"

module pcie_tlp_bridge_asserts (
    input logic                         clk_pcie,
    input logic                         rst,
    input logic [`TLP_DATA_W-1:0]       tx_data,
    input logic [`TLP_KEEP_BYTES-1:0]   tx_keep,
    input logic                         tx_last,
    input logic                         tx_valid,
    input logic                         tx_ready,
    input logic                         tx_tlp_valid,
    input logic                         tx_tlp_ready
);

    // ----------------------------------------------------------------------
    // core side, a stalled beat stays put
    // ----------------------------------------------------------------------
    property p_stalled_beat_stable;
        @(posedge clk_pcie) disable iff (rst)
        (tx_valid && !tx_ready) |=>
            (tx_valid && $stable(tx_data) && $stable(tx_keep) && $stable(tx_last));
    endproperty

    a_stalled_beat_stable: assert property (p_stalled_beat_stable)
        else $error("core-side beat changed or vanished while tx_ready was low");

    // ----------------------------------------------------------------------
    // application side, no new beat while one is held
    // ----------------------------------------------------------------------
    // blocked beat gets captured, input stays closed until the core takes it
    property p_held_blocks_ready;
        @(posedge clk_pcie) disable iff (rst)
        (!tx_ready && (tx_tlp_valid || !tx_tlp_ready)) |=> !tx_tlp_ready;
    endproperty

    a_held_blocks_ready: assert property (p_held_blocks_ready)
        else $error("tx_tlp_ready high while a blocked beat is still held");

endmodule

bind tlp_tx_adapter pcie_tlp_bridge_asserts u_tx_asserts (
    .clk_pcie     (clk_pcie),
    .rst          (rst),
    .tx_data      (tx_data),
    .tx_keep      (tx_keep),
    .tx_last      (tx_last),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .tx_tlp_valid (tx_tlp_valid),
    .tx_tlp_ready (tx_tlp_ready)
);

//--- tb/tb_pcie_tlp_bridge.sv
/*
 * rx stimulus is packed from a tlp table; no tlp may sit entirely inside qw1 of one beat
 * tx runs the beat table twice, first with tx_ready high, then with random stalls
 */
`timescale 1ns/1ps
`include "pcie_tlp_params.svh"

module tb_pcie_tlp_bridge;

    localparam int N_TLP    = 8;
    localparam int N_TX     = 12;
    localparam int MAX_SLOT = 64;

    logic                           clk_pcie;
    logic                           rst;
    pcie_tlp_pkg::tlp_beat_u        rx_data;
    pcie_tlp_pkg::rx_user_t         rx_user;
    logic                           rx_valid;
    logic                           rx_ready;
    pcie_tlp_pkg::tlp_beat_u        rx_tlp_data;
    pcie_tlp_pkg::keep_dw_t         rx_tlp_keepdw;
    logic                           rx_tlp_first;
    logic                           rx_tlp_last;
    pcie_tlp_pkg::bar_hit_t         rx_tlp_bar_hit;
    logic                           rx_tlp_valid;
    pcie_tlp_pkg::tlp_beat_u        tx_tlp_data;
    pcie_tlp_pkg::keep_dw_t         tx_tlp_keepdw;
    logic                           tx_tlp_last;
    logic                           tx_tlp_valid;
    logic                           tx_tlp_ready;
    pcie_tlp_pkg::tlp_beat_u        tx_data;
    logic [`TLP_KEEP_BYTES-1:0]     tx_keep;
    logic                           tx_last;
    logic                           tx_valid;
    logic                           tx_ready;

    // rx tlp table: start quadword, length in dwords, bar hit
    int                     tlp_sqw [N_TLP] = '{0, 0, 1, 1, 0, 1, 0, 1};
    int                     tlp_len [N_TLP] = '{4, 7, 3, 6, 7, 4, 3, 5};
    pcie_tlp_pkg::bar_hit_t tlp_bar [N_TLP] = '{7'h01, 7'h02, 7'h04, 7'h08,
                                                7'h10, 7'h20, 7'h40, 7'h03};

    // tx table: dword keep and last flag per beat
    pcie_tlp_pkg::keep_dw_t tx_keep_tab [N_TX] = '{4'hf, 4'hf, 4'h7, 4'hf, 4'h1, 4'hf,
                                                   4'hf, 4'hf, 4'h3, 4'h7, 4'hf, 4'hf};
    logic                   tx_last_tab [N_TX] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0,
                                                   1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};

    // core beat table built from the tlp table
    int                      tlp_start [N_TLP];
    int                      tlp_end   [N_TLP];
    int                      slot_tlp  [MAX_SLOT];
    int                      n_beats;
    pcie_tlp_pkg::tlp_beat_u beat_data [MAX_SLOT/4];
    pcie_tlp_pkg::rx_user_t  beat_user [MAX_SLOT/4];
    logic                    beat_gap  [MAX_SLOT/4];    // idle cycle before the beat
    logic                    beat_drop [MAX_SLOT/4];    // rx_ready expected low
    logic                    beat_aligned [MAX_SLOT/4]; // a tlp starts in dword 0

    // expected streams
    logic [31:0]             exp_rx_dw  [$];
    int                      exp_rx_tlp [$];
    int                      exp_rx_idx [$];
    pcie_tlp_pkg::tlp_beat_u exp_tx_data [$];
    pcie_tlp_pkg::keep_dw_t  exp_tx_keep [$];
    logic                    exp_tx_last [$];

    integer seed;
    logic   stall_mode;
    int     fail_count  = 0;
    int     cycle_count = 0;
    int     cycle_limit = 100000;

    pcie_tlp_bridge dut (.*);

    always #10 clk_pcie = ~clk_pcie;

    always @(posedge clk_pcie) begin
        if (stall_mode)
            tx_ready <= (($random(seed) & 3) != 0);    // roughly one stall in four
        else
            tx_ready <= 1'b1;
    end

    always @(posedge clk_pcie) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_count++;
            $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        fail_count++;
        $display("error at %0t ns: %s", $time, why);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] tlp_dword(input int k, input int i);
        return {8'(k), 8'ha5, 16'(i)};
    endfunction

    function automatic pcie_tlp_pkg::tlp_beat_u tx_beat(input int pass, input int t);
        pcie_tlp_pkg::tlp_beat_u b;
        for (int i = 0; i < `TLP_DW_PER_BEAT; i++) begin
            b.dw[i] = {8'hc0 | 8'(pass), 8'(t), 16'(i * 16'h1111)};
        end
        return b;
    endfunction

    // each dword bit covers four byte bits
    function automatic logic [`TLP_KEEP_BYTES-1:0] byte_keep(input pcie_tlp_pkg::keep_dw_t k);
        logic [`TLP_KEEP_BYTES-1:0] e;
        for (int i = 0; i < `TLP_DW_PER_BEAT; i++) begin
            for (int j = 0; j < 4; j++) begin
                e[i*4+j] = k[i];
            end
        end
        return e;
    endfunction

    // ----------------------------------------------------------------------
    // rx beat table and reference dword stream
    // ----------------------------------------------------------------------
    task automatic build_rx_table();
        int pos;
        int s;
        int k;
        pos = 0;
        for (int i = 0; i < MAX_SLOT; i++) begin
            slot_tlp[i] = -1;
        end
        for (int t = 0; t < N_TLP; t++) begin
            s = ((pos + 1) / 2) * 2;                    // next quadword boundary
            if ((s % 4 == 2) != (tlp_sqw[t] == 1))
                s += 2;
            tlp_start[t] = s;
            tlp_end[t]   = s + tlp_len[t] - 1;
            for (int i = 0; i < tlp_len[t]; i++) begin
                slot_tlp[s+i] = t;
                exp_rx_dw.push_back(tlp_dword(t, i));
                exp_rx_tlp.push_back(t);
                exp_rx_idx.push_back(i);
            end
            pos = tlp_end[t] + 1;
        end
        n_beats = (pos + 3) / 4;
        for (int b = 0; b < n_beats; b++) begin
            beat_user[b]    = '0;
            beat_drop[b]    = 1'b0;
            beat_aligned[b] = 1'b0;
            for (int j = 0; j < `TLP_DW_PER_BEAT; j++) begin
                k = slot_tlp[4*b+j];
                if (k >= 0) begin
                    beat_data[b].dw[j] = tlp_dword(k, 4*b + j - tlp_start[k]);
                    beat_user[b][`RX_USER_BAR_HI:`RX_USER_BAR_LO] = tlp_bar[k];
                end else begin
                    beat_data[b].dw[j] = 32'hf111_0000 | 32'(4*b + j);   // filler
                end
            end
            for (int t = 0; t < N_TLP; t++) begin
                if (tlp_start[t] / 4 == b) begin
                    beat_user[b][`RX_USER_SOF]    = 1'b1;
                    beat_user[b][`RX_USER_SOF_QW] = (tlp_start[t] % 4 == 2);
                    beat_user[b][`RX_USER_BAR_HI:`RX_USER_BAR_LO] = tlp_bar[t];
                    beat_aligned[b] = (tlp_start[t] % 4 == 0);
                end
                if (tlp_end[t] / 4 == b) begin
                    beat_user[b][`RX_USER_EOF] = 1'b1;
                    beat_user[b][`RX_USER_EOF_DW_HI:`RX_USER_EOF_DW_LO] = 2'(tlp_end[t] % 4);
                    // held qw plus two more quadwords
                    if (tlp_start[t] % 4 == 2 && tlp_end[t] % 4 >= 2)
                        beat_drop[b] = 1'b1;
                end
            end
            beat_gap[b] = (b % 4 == 1);
        end
    endtask

    // a beat seen with rx_ready low is taken, then held one more cycle
    task automatic drive_rx();
        for (int b = 0; b < n_beats; b++) begin
            if (beat_gap[b]) begin
                @(posedge clk_pcie);
                rx_valid <= 1'b0;
            end
            @(posedge clk_pcie);
            rx_data  <= beat_data[b];
            rx_user  <= beat_user[b];
            rx_valid <= 1'b1;
            @(negedge clk_pcie);
            check_value(128'(rx_ready), 128'(!beat_drop[b]), "rx ready");
            if (beat_aligned[b])
                check_value(128'(rx_tlp_valid && rx_tlp_first), 128'(1),
                            "aligned tlp start on the rx output");
            if (beat_drop[b])
                @(posedge clk_pcie);
        end
        @(posedge clk_pcie);
        rx_valid <= 1'b0;
    endtask

    task automatic check_rx_beat();
        int k;
        int idx;
        logic [31:0] dw;
        k   = 0;
        idx = 0;
        check_value(128'(rx_tlp_keepdw inside {4'b0001, 4'b0011, 4'b0111, 4'b1111}),
                    128'(1), "rx keep not contiguous from dword 0");
        for (int j = 0; j < `TLP_DW_PER_BEAT; j++) begin
            if (rx_tlp_keepdw[j]) begin
                if (exp_rx_dw.size() == 0)
                    abort_run("receive output carries more dwords than were sent");
                dw  = exp_rx_dw.pop_front();
                k   = exp_rx_tlp.pop_front();
                idx = exp_rx_idx.pop_front();
                check_value(128'(rx_tlp_data.dw[j]), 128'(dw), "rx dword");
                check_value(128'(rx_tlp_bar_hit), 128'(tlp_bar[k]), "rx bar hit");
                if (j == 0)
                    check_value(128'(rx_tlp_first), 128'(idx == 0), "rx first flag");
            end
        end
        check_value(128'(rx_tlp_last), 128'(idx == tlp_len[k] - 1), "rx last flag");
    endtask

    always @(negedge clk_pcie) begin
        if (!rst && rx_tlp_valid)
            check_rx_beat();
    end

    // ----------------------------------------------------------------------
    // tx path
    // ----------------------------------------------------------------------
    task automatic run_tx_pass(input int pass);
        logic accepted;
        @(posedge clk_pcie);
        stall_mode <= (pass == 1);
        for (int t = 0; t < N_TX; t++) begin
            exp_tx_data.push_back(tx_beat(pass, t));
            exp_tx_keep.push_back(tx_keep_tab[t]);
            exp_tx_last.push_back(tx_last_tab[t]);
        end
        for (int t = 0; t < N_TX; t++) begin
            accepted = 1'b0;
            while (!accepted) begin
                @(posedge clk_pcie);
                tx_tlp_data   <= tx_beat(pass, t);
                tx_tlp_keepdw <= tx_keep_tab[t];
                tx_tlp_last   <= tx_last_tab[t];
                tx_tlp_valid  <= 1'b1;
                @(negedge clk_pcie);
                accepted = tx_tlp_ready;
            end
        end
        @(posedge clk_pcie);
        tx_tlp_valid <= 1'b0;
        while (exp_tx_data.size() != 0)
            @(posedge clk_pcie);
    endtask

    always @(negedge clk_pcie) begin
        if (!rst && tx_valid && tx_ready) begin
            if (exp_tx_data.size() == 0)
                abort_run("core side sent a beat that was never driven");
            check_value(128'(tx_data), 128'(exp_tx_data.pop_front()), "tx data");
            check_value(128'(tx_keep), 128'(byte_keep(exp_tx_keep.pop_front())), "tx keep");
            check_value(128'(tx_last), 128'(exp_tx_last.pop_front()), "tx last");
        end
    end

    initial begin
        seed          = 32'h42f6a462;
        clk_pcie      = 1'b0;
        rst           = 1'b1;
        rx_data       = '0;
        rx_user       = '0;
        rx_valid      = 1'b0;
        tx_tlp_data   = '0;
        tx_tlp_keepdw = '0;
        tx_tlp_last   = 1'b0;
        tx_tlp_valid  = 1'b0;
        tx_ready      = 1'b1;
        stall_mode    = 1'b0;
        build_rx_table();
        cycle_limit = 4 * (n_beats + 2 * N_TX + 4);
        repeat (4) @(posedge clk_pcie);
        rst <= 1'b0;
        drive_rx();
        while (exp_rx_dw.size() != 0)
            @(posedge clk_pcie);
        run_tx_pass(0);
        run_tx_pass(1);
        repeat (2) @(posedge clk_pcie);
        if (fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- verilog/pcie_tlp_bridge.sv
/*
 * rx and tx tlp paths between the core user streams and the application
 * single clock clk_pcie, single synchronous reset
 */
`timescale 1ns/1ps
`include "pcie_tlp_params.svh"

module pcie_tlp_bridge (
    input  logic                        clk_pcie,
    input  logic                        rst,

    // core receive
    input  pcie_tlp_pkg::tlp_beat_u     rx_data,
    input  pcie_tlp_pkg::rx_user_t      rx_user,
    input  logic                        rx_valid,
    output logic                        rx_ready,

    // application receive, no back-pressure
    output pcie_tlp_pkg::tlp_beat_u     rx_tlp_data,
    output pcie_tlp_pkg::keep_dw_t      rx_tlp_keepdw,
    output logic                        rx_tlp_first,
    output logic                        rx_tlp_last,
    output pcie_tlp_pkg::bar_hit_t      rx_tlp_bar_hit,
    output logic                        rx_tlp_valid,

    // application transmit
    input  pcie_tlp_pkg::tlp_beat_u     tx_tlp_data,
    input  pcie_tlp_pkg::keep_dw_t      tx_tlp_keepdw,
    input  logic                        tx_tlp_last,
    input  logic                        tx_tlp_valid,
    output logic                        tx_tlp_ready,

    // core transmit
    output pcie_tlp_pkg::tlp_beat_u     tx_data,
    output logic [`TLP_KEEP_BYTES-1:0]  tx_keep,
    output logic                        tx_last,
    output logic                        tx_valid,
    input  logic                        tx_ready
);

    // ----------------------------------------------------------------------
    // receive path
    // ----------------------------------------------------------------------
    tlp_rx_realign u_rx_realign (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .rx_data        (rx_data),
        .rx_user        (rx_user),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .rx_tlp_data    (rx_tlp_data),
        .rx_tlp_keepdw  (rx_tlp_keepdw),
        .rx_tlp_first   (rx_tlp_first),
        .rx_tlp_last    (rx_tlp_last),
        .rx_tlp_bar_hit (rx_tlp_bar_hit),
        .rx_tlp_valid   (rx_tlp_valid)
    );

    // ----------------------------------------------------------------------
    // transmit path
    // ----------------------------------------------------------------------
    tlp_tx_adapter u_tx_adapter (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .tx_tlp_data    (tx_tlp_data),
        .tx_tlp_keepdw  (tx_tlp_keepdw),
        .tx_tlp_last    (tx_tlp_last),
        .tx_tlp_valid   (tx_tlp_valid),
        .tx_tlp_ready   (tx_tlp_ready),
        .tx_data        (tx_data),
        .tx_keep        (tx_keep),      // byte keep toward the core
        .tx_last        (tx_last),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready)
    );

endmodule

//--- verilog/pcie_tlp_pkg.sv
/*
 * shared types of the tlp bridge
 * dword 0 and quadword 0 of a beat sit at bit 0
 */
`include "pcie_tlp_params.svh"

package pcie_tlp_pkg;

    // ----------------------------------------------------------------------
    // beat
    // ----------------------------------------------------------------------

    // one beat, read as quadwords by the rx realigner
    // and as dwords by the tx keep expansion
    typedef union packed {
        logic [`TLP_DATA_W/`TLP_QW_W-1:0][`TLP_QW_W-1:0]   qw;
        logic [`TLP_DW_PER_BEAT-1:0][`TLP_DW_W-1:0]       dw;
    } tlp_beat_u;

    typedef logic [`TLP_DW_PER_BEAT-1:0] keep_dw_t;    // one bit per dword

    // ----------------------------------------------------------------------
    // core receive side
    // ----------------------------------------------------------------------

    // raw user word as delivered by the core
    typedef logic [`RX_USER_W-1:0] rx_user_t;

    // index of the last valid dword in an eof beat
    typedef logic [`RX_USER_EOF_DW_HI-`RX_USER_EOF_DW_LO:0] eof_dw_t;

    typedef logic [`BAR_HIT_W-1:0] bar_hit_t;

endpackage

//--- verilog/tlp_rx_realign.sv
/*
 * rx output has no ready; every valid beat must be taken by the application
 * core must hold its beat while rx_ready is low, the beat is consumed in that cycle
 */
`timescale 1ns/1ps
`include "pcie_tlp_params.svh"

module tlp_rx_realign (
    input  logic                    clk_pcie,
    input  logic                    rst,
    input  pcie_tlp_pkg::tlp_beat_u rx_data,
    input  pcie_tlp_pkg::rx_user_t  rx_user,
    input  logic                    rx_valid,
    output logic                    rx_ready,
    output pcie_tlp_pkg::tlp_beat_u rx_tlp_data,
    output pcie_tlp_pkg::keep_dw_t  rx_tlp_keepdw,
    output logic                    rx_tlp_first,
    output logic                    rx_tlp_last,
    output pcie_tlp_pkg::bar_hit_t  rx_tlp_bar_hit,
    output logic                    rx_tlp_valid
);

    // decoded core beat
    logic                   beat_sof;
    logic                   beat_sof_qw;
    logic                   beat_eof;
    pcie_tlp_pkg::eof_dw_t  beat_eof_dw;
    pcie_tlp_pkg::bar_hit_t beat_bar;
    logic                   beat_valid;
    logic                   ready_q;        // rx_ready of the previous cycle

    // held upper quadword and its tlp state
    logic                   hold_valid;
    logic [`TLP_QW_W-1:0]   hold_qw;
    logic                   hold_sof;
    logic                   hold_eof;       // tlp ends inside the held qw
    logic                   hold_eof_dw3;   // two dwords left instead of one
    pcie_tlp_pkg::bar_hit_t hold_bar;
    logic                   hold_next;
    logic                   hold_adv;

    // dwords 0..last_dw set
    function automatic pcie_tlp_pkg::keep_dw_t keep_upto(
        input pcie_tlp_pkg::eof_dw_t last_dw
    );
        pcie_tlp_pkg::keep_dw_t k;
        for (int i = 0; i < `TLP_DW_PER_BEAT; i++) begin
            k[i] = (i <= int'(last_dw));
        end
        return k;
    endfunction

    // ----------------------------------------------------------------------
    // user word decode
    // ----------------------------------------------------------------------
    assign beat_sof    = rx_user[`RX_USER_SOF];
    assign beat_sof_qw = rx_user[`RX_USER_SOF_QW];
    assign beat_eof    = rx_user[`RX_USER_EOF];
    assign beat_eof_dw = rx_user[`RX_USER_EOF_DW_HI:`RX_USER_EOF_DW_LO];
    assign beat_bar    = rx_user[`RX_USER_BAR_HI:`RX_USER_BAR_LO];

    // repeat of a beat already taken while rx_ready was low
    assign beat_valid = rx_valid && ready_q;

    // two quadwords still to go, only one fits next to the held one
    assign rx_ready = !(beat_valid && hold_valid && beat_eof && beat_eof_dw[1]);

    // ----------------------------------------------------------------------
    // output mux, direct beat or held qw joined with the new lower qw
    // ----------------------------------------------------------------------
    always_comb begin
        rx_tlp_data   = rx_data;
        rx_tlp_keepdw = `TLP_KEEPDW_RST;
        if (hold_valid) begin
            rx_tlp_data.qw[0] = hold_qw;
            rx_tlp_data.qw[1] = rx_data.qw[0];
            rx_tlp_first      = hold_sof;
            rx_tlp_last       = hold_eof || (beat_eof && !beat_eof_dw[1]);
            rx_tlp_bar_hit    = hold_bar;
            rx_tlp_valid      = hold_eof || beat_valid;   // wait for the partner qw
            if (hold_eof) begin
                rx_tlp_keepdw = keep_upto({1'b0, hold_eof_dw3});
            end else if (beat_valid && beat_eof && !beat_eof_dw[1]) begin
                rx_tlp_keepdw = keep_upto({1'b1, beat_eof_dw[0]});
            end else if (beat_valid) begin
                rx_tlp_keepdw = '1;
            end
        end else begin
            rx_tlp_first   = beat_sof && !beat_sof_qw;
            rx_tlp_last    = beat_eof;
            rx_tlp_bar_hit = beat_bar;
            // a tlp starting in qw1 waits one cycle unless an earlier tlp ends here
            rx_tlp_valid   = beat_valid && (beat_eof || !(beat_sof && beat_sof_qw));
            if (beat_valid) begin
                rx_tlp_keepdw = beat_eof ? keep_upto(beat_eof_dw) : '1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // held quadword
    // ----------------------------------------------------------------------
    always_comb begin
        if (hold_valid) begin
            hold_next = !hold_eof && beat_valid &&
                        ((!beat_sof && !beat_eof) ||        // tlp continues
                         (beat_sof && beat_sof_qw) ||       // next tlp starts in qw1
                         (beat_eof && beat_eof_dw[1]));     // remainder in qw1
        end else begin
            hold_next = beat_valid && beat_sof && beat_sof_qw;
        end
    end

    // a held qw without eof stays until the next core beat shows up
    assign hold_adv = beat_valid || (hold_valid && hold_eof);

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            ready_q    <= 1'b1;
            hold_valid <= 1'b0;
        end else begin
            ready_q <= rx_ready;
            if (hold_adv)
                hold_valid <= hold_next;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (beat_valid) begin
            hold_qw      <= rx_data.qw[1];
            hold_sof     <= beat_sof && beat_sof_qw;
            hold_eof     <= beat_eof && beat_eof_dw[1];
            hold_eof_dw3 <= (beat_eof_dw == 2'd3);
            hold_bar     <= beat_bar;
        end
    end

endmodule

//--- verilog/tlp_tx_adapter.sv
/*
 * one-entry skid buffer; tx_tlp_ready depends only on the skid state
 * a blocked beat is taken from the application and sent before any later beat
 */
`timescale 1ns/1ps
`include "pcie_tlp_params.svh"

module tlp_tx_adapter (
    input  logic                        clk_pcie,
    input  logic                        rst,
    input  pcie_tlp_pkg::tlp_beat_u     tx_tlp_data,
    input  pcie_tlp_pkg::keep_dw_t      tx_tlp_keepdw,
    input  logic                        tx_tlp_last,
    input  logic                        tx_tlp_valid,
    output logic                        tx_tlp_ready,
    output pcie_tlp_pkg::tlp_beat_u     tx_data,
    output logic [`TLP_KEEP_BYTES-1:0]  tx_keep,
    output logic                        tx_last,
    output logic                        tx_valid,
    input  logic                        tx_ready
);

    localparam int BYTES_PER_DW = `TLP_KEEP_BYTES / `TLP_DW_PER_BEAT;

    logic                    skid_valid;
    pcie_tlp_pkg::tlp_beat_u skid_data;
    pcie_tlp_pkg::keep_dw_t  skid_keepdw;
    logic                    skid_last;
    pcie_tlp_pkg::keep_dw_t  out_keepdw;

    // ----------------------------------------------------------------------
    // skid register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            skid_valid <= 1'b0;
        end else if (!skid_valid) begin
            skid_valid <= tx_tlp_valid && !tx_ready;    // core blocked the live beat
        end else if (tx_ready) begin
            skid_valid <= 1'b0;                         // held beat went out
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (!skid_valid) begin
            skid_data   <= tx_tlp_data;
            skid_keepdw <= tx_tlp_keepdw;
            skid_last   <= tx_tlp_last;
        end
    end

    assign tx_tlp_ready = !skid_valid;

    // ----------------------------------------------------------------------
    // output mux and keep expansion
    // ----------------------------------------------------------------------
    assign tx_valid   = skid_valid || tx_tlp_valid;
    assign tx_last    = skid_valid ? skid_last : tx_tlp_last;
    assign out_keepdw = skid_valid ? skid_keepdw : tx_tlp_keepdw;

    always_comb begin
        for (int i = 0; i < `TLP_DW_PER_BEAT; i++) begin
            tx_data.dw[i] = skid_valid ? skid_data.dw[i] : tx_tlp_data.dw[i];
            tx_keep[i*BYTES_PER_DW +: BYTES_PER_DW] = {BYTES_PER_DW{out_keepdw[i]}};
        end
    end

endmodule
